//--- rtl/axi_pkg.sv
package axi_pkg;

    // ----------------------------------------
    // Bus and memory geometry
    // ----------------------------------------
    localparam int AXI_AW    = 16;
    localparam int AXI_DW    = 32;
    localparam int AXI_BC    = AXI_DW / 8;
    localparam int AXI_BW    = 2;
    localparam int AXI_IW    = 4;
    localparam int AXI_UW    = 8;
    localparam int MEM_WORDS = 64;
    localparam int MEM_IDX_W = 6;

    // AWBURST encoding, 2'b11 is reserved
    typedef enum logic [1:0] {
        AXI_BURST_FIXED = 2'b00,
        AXI_BURST_INCR  = 2'b01,
        AXI_BURST_WRAP  = 2'b10
    } axi_burst_e;

    // BRESP encoding, EXOKAY and DECERR never returned
    typedef enum logic [1:0] {
        AXI_RESP_OKAY   = 2'b00,
        AXI_RESP_SLVERR = 2'b10
    } axi_resp_e;

    // Write request as captured from AW
    typedef struct packed {
        logic [AXI_AW-1:0] addr;
        axi_burst_e        burst;
        logic [2:0]        size;
        logic [7:0]        len;
        logic [AXI_UW-1:0] user;
        logic [AXI_IW-1:0] id;
    } axi_ctx_t;

endpackage

//--- rtl/axi_if.sv
`timescale 1ns/10ps

interface axi_if import axi_pkg::*; ();

    // Write address channel
    logic              awvalid;
    logic              awready;
    logic [AXI_AW-1:0] awaddr;
    axi_burst_e        awburst;
    logic [2:0]        awsize;
    logic [7:0]        awlen;
    logic [AXI_UW-1:0] awuser;
    logic [AXI_IW-1:0] awid;

    // Write data channel
    logic              wvalid;
    logic              wready;
    logic [AXI_DW-1:0] wdata;
    logic [AXI_BC-1:0] wstrb;
    logic              wlast;

    // Write response channel
    logic              bvalid;
    logic              bready;
    axi_resp_e         bresp;
    logic [AXI_IW-1:0] bid;

    // Subordinate side
    modport w_sub (
        input  awvalid, awaddr, awburst, awsize, awlen, awuser, awid,
        input  wvalid, wdata, wstrb, wlast, bready,
        output awready, wready, bvalid, bresp, bid
    );

    // Manager side
    modport w_mgr (
        output awvalid, awaddr, awburst, awsize, awlen, awuser, awid,
        output wvalid, wdata, wstrb, wlast, bready,
        input  awready, wready, bvalid, bresp, bid
    );

endinterface

//--- rtl/comp_wr_if.sv
`timescale 1ns/10ps

interface comp_wr_if import axi_pkg::*; ();

    // One beat per dv, consumed when hld is low
    logic              dv;
    // Word aligned byte address
    logic [AXI_AW-1:0] addr;
    logic [AXI_IW-1:0] id;
    logic [AXI_DW-1:0] wdata;
    logic [AXI_BC-1:0] wstrb;
    logic [2:0]        wsize;
    // Final beat of the burst
    logic              last;
    // Component stall and per-beat error
    logic              hld;
    logic              err;

    modport sub (
        output dv, addr, id, wdata, wstrb, wsize, last,
        input  hld, err
    );

    modport comp (
        input  dv, addr, id, wdata, wstrb, wsize, last,
        output hld, err
    );

endinterface

//--- rtl/skid_buffer.sv
`timescale 1ns/10ps

module skid_buffer #(
    parameter int DW         = 8,
    parameter bit OPT_OUTREG = 1'b0
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          i_valid,
    output logic          o_ready,
    input  logic [DW-1:0] i_data,
    output logic          o_valid,
    input  logic          i_ready,
    output logic [DW-1:0] o_data
);

    // Spare slot, filled only when the output side stalls
    logic          r_valid;
    logic [DW-1:0] r_data;

    // Upstream sees ready only while the spare slot is free
    assign o_ready = !r_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_valid <= 1'b0;
        end else if (i_valid && o_ready && o_valid && !i_ready) begin
            r_valid <= 1'b1;
        end else if (i_ready) begin
            r_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (o_ready) begin
            r_data <= i_data;
        end
    end

    // ----------------------------------------
    // Output stage
    // ----------------------------------------
    if (OPT_OUTREG) begin : g_outreg
        // Output register reloads whenever it is empty or drained
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                o_valid <= 1'b0;
            end else if (!o_valid || i_ready) begin
                o_valid <= i_valid || r_valid;
            end
        end

        always_ff @(posedge clk) begin
            if (!o_valid || i_ready) begin
                o_data <= r_valid ? r_data : i_data;
            end
        end
    end else begin : g_comb
        // Pass through, spare slot takes priority
        assign o_valid = i_valid || r_valid;
        assign o_data  = r_valid ? r_data : i_data;
    end

endmodule

//--- rtl/axi_addr_step.sv
`timescale 1ns/10ps

module axi_addr_step import axi_pkg::*; (
    input  logic [AXI_AW-1:0] i_last_addr,
    input  logic [2:0]        i_size,
    input  axi_burst_e        i_burst,
    input  logic [7:0]        i_len,
    output logic [AXI_AW-1:0] o_next_addr
);

    logic [AXI_AW-1:0] beat_bytes;
    logic [AXI_AW-1:0] addr_algn;
    logic [AXI_AW-1:0] addr_incr;
    logic [AXI_AW-1:0] wrap_mask;
    logic [AXI_AW-1:0] addr_wrap;

    // Bytes per beat from AWSIZE
    assign beat_bytes = AXI_AW'(1) << i_size;

    // Align down to the beat size, then step one beat
    assign addr_algn = i_last_addr & ~(beat_bytes - AXI_AW'(1));
    assign addr_incr = addr_algn + beat_bytes;

    // Wrap window is size * (len+1) bytes, a power of two for legal WRAP
    assign wrap_mask = (beat_bytes * (AXI_AW'(i_len) + AXI_AW'(1))) - AXI_AW'(1);
    // Keep the window base, take the offset from the stepped address
    assign addr_wrap = (i_last_addr & ~wrap_mask) | (addr_incr & wrap_mask);

    always_comb begin
        case (i_burst)
            AXI_BURST_INCR: o_next_addr = addr_incr;
            AXI_BURST_WRAP: o_next_addr = addr_wrap;
            // FIXED and reserved hold the address
            default:        o_next_addr = i_last_addr;
        endcase
    end

endmodule

//--- rtl/axi_sub_wr.sv
`timescale 1ns/10ps

module axi_sub_wr import axi_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    axi_if.w_sub   s_axi,
    comp_wr_if.sub comp
);

    logic                   out_of_rst;
    logic                   awvalid_q;
    logic                   awready_q;
    axi_ctx_t               aw_ctx;
    axi_ctx_t               req_ctx;
    logic                   req_valid;
    logic                   req_ready;
    axi_ctx_t               txn_ctx;
    logic [AXI_AW-1:0]      txn_addr_nxt;
    logic                   txn_active;
    logic                   txn_err;
    logic                   txn_final_beat;
    logic                   txn_wvalid;
    logic                   txn_wready;
    logic                   beat_take;
    logic                   dv_pre;
    logic [AXI_DW+AXI_BC:0] dp_in;
    logic [AXI_DW+AXI_BC:0] dp_out;
    logic                   rp_valid;
    logic                   rp_ready;
    axi_resp_e              rp_resp;
    logic [AXI_IW+1:0]      rp_in;
    logic [AXI_IW+1:0]      rp_out;

    // ----------------------------------------
    // Request path
    // ----------------------------------------
    // AW is held off for the first cycle out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_of_rst <= 1'b0;
        end else begin
            out_of_rst <= 1'b1;
        end
    end

    assign awvalid_q     = s_axi.awvalid && out_of_rst;
    assign s_axi.awready = awready_q && out_of_rst;

    assign aw_ctx = '{addr: s_axi.awaddr, burst: s_axi.awburst, size: s_axi.awsize,
                      len: s_axi.awlen, user: s_axi.awuser, id: s_axi.awid};

    skid_buffer #(.DW($bits(axi_ctx_t)), .OPT_OUTREG(1'b0)) u_req_skd (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_valid(awvalid_q),
        .o_ready(awready_q),
        .i_data (aw_ctx),
        .o_valid(req_valid),
        .i_ready(req_ready),
        .o_data (req_ctx)
    );

    // Start a burst only with a free response slot guaranteed
    assign req_ready = (!txn_active || (txn_final_beat && !s_axi.bvalid)) && rp_ready;

    assign beat_take      = comp.dv && !comp.hld;
    assign txn_final_beat = beat_take && comp.last;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txn_active <= 1'b0;
            txn_err    <= 1'b0;
        end else if (req_valid && req_ready) begin
            txn_active <= 1'b1;
            txn_err    <= 1'b0;
        end else if (beat_take) begin
            // Sticky over the burst
            txn_err    <= txn_err || comp.err;
            txn_active <= !comp.last;
        end
    end

    // Active context, address steps once per consumed beat
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            txn_ctx <= req_ctx;
        end else if (beat_take) begin
            txn_ctx.addr <= txn_addr_nxt;
        end
    end

    axi_addr_step u_addr_step (
        .i_last_addr(txn_ctx.addr),
        .i_size     (txn_ctx.size),
        .i_burst    (txn_ctx.burst),
        .i_len      (txn_ctx.len),
        .o_next_addr(txn_addr_nxt)
    );

    // Component sees word aligned addresses only
    assign comp.addr  = {txn_ctx.addr[AXI_AW-1:AXI_BW], AXI_BW'(0)};
    assign comp.id    = txn_ctx.id;
    assign comp.wsize = txn_ctx.size;

    // ----------------------------------------
    // Data path
    // ----------------------------------------
    // W only flows while a burst context is loaded
    assign txn_wvalid   = s_axi.wvalid && txn_active;
    assign s_axi.wready = txn_wready && txn_active;
    assign dp_in        = {s_axi.wdata, s_axi.wstrb, s_axi.wlast};

    skid_buffer #(.DW(AXI_DW + AXI_BC + 1), .OPT_OUTREG(1'b0)) u_dp_skd (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_valid(txn_wvalid),
        .o_ready(txn_wready),
        .i_data (dp_in),
        .o_valid(dv_pre),
        .i_ready(!comp.hld && txn_active),
        .o_data (dp_out)
    );

    // A beat parked ahead of its AW waits for the context
    assign comp.dv    = dv_pre && txn_active;
    assign comp.wdata = dp_out[AXI_DW+AXI_BC:AXI_BC+1];
    assign comp.wstrb = dp_out[AXI_BC:1];
    assign comp.last  = dp_out[0];

    // ----------------------------------------
    // Response path
    // ----------------------------------------
    assign rp_valid = txn_final_beat;
    assign rp_resp  = (txn_err || comp.err) ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
    assign rp_in    = {rp_resp, txn_ctx.id};

    // Registered output, spare slot absorbs one stalled response
    skid_buffer #(.DW(AXI_IW + 2), .OPT_OUTREG(1'b1)) u_rsp_skd (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_valid(rp_valid),
        .o_ready(rp_ready),
        .i_data (rp_in),
        .o_valid(s_axi.bvalid),
        .i_ready(s_axi.bready),
        .o_data (rp_out)
    );

    assign s_axi.bresp = axi_resp_e'(rp_out[AXI_IW+1:AXI_IW]);
    assign s_axi.bid   = rp_out[AXI_IW-1:0];

endmodule

//--- rtl/wr_mem.sv
`timescale 1ns/10ps

module wr_mem import axi_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    comp_wr_if.comp              mem,
    input  logic                 i_rd_en,
    input  logic [MEM_IDX_W-1:0] i_rd_addr,
    output logic [AXI_DW-1:0]    o_rd_data
);

    logic [AXI_DW-1:0]    mem_q [MEM_WORDS];
    logic [MEM_IDX_W-1:0] wr_idx;
    logic                 wr_en;

    // Word index is the byte address shifted right by two
    assign wr_idx = mem.addr[AXI_BW +: MEM_IDX_W];

    // Any upper index bit set means past word 63
    assign mem.err = |mem.addr[AXI_AW-1:AXI_BW+MEM_IDX_W];

    // Single port, reads win
    assign mem.hld = i_rd_en;

    // Out of range beats are consumed but dropped
    assign wr_en = mem.dv && !mem.hld && !mem.err;

    // ----------------------------------------
    // Byte strobed write
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < AXI_BC; b++) begin
                if (mem.wstrb[b]) begin
                    mem_q[wr_idx][8*b +: 8] <= mem.wdata[8*b +: 8];
                end
            end
        end
    end

    // Registered read, data one cycle after i_rd_en
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_rd_data <= '0;
        end else if (i_rd_en) begin
            o_rd_data <= mem_q[i_rd_addr];
        end
    end

endmodule

//--- rtl/axi_wr_mem_top.sv
`timescale 1ns/10ps

module axi_wr_mem_top import axi_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    // Write address
    input  logic                 i_awvalid,
    output logic                 o_awready,
    input  logic [AXI_AW-1:0]    i_awaddr,
    input  logic [1:0]           i_awburst,
    input  logic [2:0]           i_awsize,
    input  logic [7:0]           i_awlen,
    input  logic [AXI_UW-1:0]    i_awuser,
    input  logic [AXI_IW-1:0]    i_awid,
    // Write data
    input  logic                 i_wvalid,
    output logic                 o_wready,
    input  logic [AXI_DW-1:0]    i_wdata,
    input  logic [AXI_BC-1:0]    i_wstrb,
    input  logic                 i_wlast,
    // Write response
    output logic                 o_bvalid,
    input  logic                 i_bready,
    output logic [1:0]           o_bresp,
    output logic [AXI_IW-1:0]    o_bid,
    // Read port
    input  logic                 i_rd_en,
    input  logic [MEM_IDX_W-1:0] i_rd_addr,
    output logic [AXI_DW-1:0]    o_rd_data
);

    axi_if     axi0 ();
    comp_wr_if comp0 ();

    // Manager side of the bus from plain ports
    assign axi0.awvalid = i_awvalid;
    assign axi0.awaddr  = i_awaddr;
    assign axi0.awburst = axi_burst_e'(i_awburst);
    assign axi0.awsize  = i_awsize;
    assign axi0.awlen   = i_awlen;
    assign axi0.awuser  = i_awuser;
    assign axi0.awid    = i_awid;
    assign axi0.wvalid  = i_wvalid;
    assign axi0.wdata   = i_wdata;
    assign axi0.wstrb   = i_wstrb;
    assign axi0.wlast   = i_wlast;
    assign axi0.bready  = i_bready;

    assign o_awready = axi0.awready;
    assign o_wready  = axi0.wready;
    assign o_bvalid  = axi0.bvalid;
    assign o_bresp   = axi0.bresp;
    assign o_bid     = axi0.bid;

    axi_sub_wr u_sub (
        .clk  (clk),
        .rst_n(rst_n),
        .s_axi(axi0.w_sub),
        .comp (comp0.sub)
    );

    wr_mem u_mem (
        .clk      (clk),
        .rst_n    (rst_n),
        .mem      (comp0.comp),
        .i_rd_en  (i_rd_en),
        .i_rd_addr(i_rd_addr),
        .o_rd_data(o_rd_data)
    );

endmodule

//--- bench/tb_axi_wr_mem.sv
`timescale 1ns/10ps

module tb_axi_wr_mem import axi_pkg::*; ();

    // Fill burst, six tests and read sweeps stay below about 600 cycles
    localparam int CYCLE_LIMIT = 4000;

    logic                 clk;
    logic                 rst_n;
    logic                 i_awvalid;
    logic                 o_awready;
    logic [AXI_AW-1:0]    i_awaddr;
    logic [1:0]           i_awburst;
    logic [2:0]           i_awsize;
    logic [7:0]           i_awlen;
    logic [AXI_UW-1:0]    i_awuser;
    logic [AXI_IW-1:0]    i_awid;
    logic                 i_wvalid;
    logic                 o_wready;
    logic [AXI_DW-1:0]    i_wdata;
    logic [AXI_BC-1:0]    i_wstrb;
    logic                 i_wlast;
    logic                 o_bvalid;
    logic                 i_bready;
    logic [1:0]           o_bresp;
    logic [AXI_IW-1:0]    o_bid;
    logic                 i_rd_en;
    logic [MEM_IDX_W-1:0] i_rd_addr;
    logic [AXI_DW-1:0]    o_rd_data;

    // Reference memory and expected {bresp, bid} in issue order
    logic [AXI_DW-1:0]    model [MEM_WORDS];
    logic [AXI_IW+1:0]    exp_q [$];
    integer               seed;
    int                   err_cnt;
    int                   err_mark;
    int                   pass_cnt;
    int                   fail_cnt;
    int                   cycle_cnt;
    bit                   resp_done;

    axi_wr_mem_top dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_awvalid(i_awvalid),
        .o_awready(o_awready),
        .i_awaddr (i_awaddr),
        .i_awburst(i_awburst),
        .i_awsize (i_awsize),
        .i_awlen  (i_awlen),
        .i_awuser (i_awuser),
        .i_awid   (i_awid),
        .i_wvalid (i_wvalid),
        .o_wready (o_wready),
        .i_wdata  (i_wdata),
        .i_wstrb  (i_wstrb),
        .i_wlast  (i_wlast),
        .o_bvalid (o_bvalid),
        .i_bready (i_bready),
        .o_bresp  (o_bresp),
        .o_bid    (o_bid),
        .i_rd_en  (i_rd_en),
        .i_rd_addr(i_rd_addr),
        .o_rd_data(o_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Watchdog
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: simulation ran for %0d cycles without finishing", cycle_cnt);
        $display("TB FAILED");
        $finish;
    end

    // ----------------------------------------
    // Reporting
    // ----------------------------------------
    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, want);
        err_cnt++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s", msg);
        err_cnt++;
    endtask

    task automatic end_test(input string name);
        if (err_cnt == err_mark) begin
            pass_cnt++;
            $display("test %s: pass", name);
        end else begin
            fail_cnt++;
            $display("test %s: fail with %0d errors", name, err_cnt - err_mark);
        end
        err_mark = err_cnt;
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic void model_write(input logic [5:0] idx, input logic [31:0] data,
                                        input logic [3:0] strb);
        for (int b = 0; b < AXI_BC; b++) begin
            if (strb[b]) begin
                model[idx][8*b +: 8] = data[8*b +: 8];
            end
        end
    endfunction

    // Next beat address for 4 byte beats
    function automatic logic [15:0] next_beat_addr(input logic [15:0] cur,
                                                   input logic [15:0] start,
                                                   input axi_burst_e burst,
                                                   input logic [7:0] len);
        logic [15:0] step;
        logic [15:0] win;
        logic [15:0] base;
        step = (cur & 16'hfffc) + 16'd4;
        // WRAP window spans all beats, base is the start rounded down to it
        win  = 16'd4 * (16'(len) + 16'd1);
        base = start - (start % win);
        case (burst)
            AXI_BURST_FIXED: return cur;
            AXI_BURST_WRAP:  return base + ((step - base) % win);
            default:         return step;
        endcase
    endfunction

    // ----------------------------------------
    // Bus drivers, entered on a falling edge
    // ----------------------------------------
    task automatic send_burst(input logic [15:0] start, input axi_burst_e burst,
                              input logic [7:0] len, input logic [3:0] id,
                              input bit rand_strb, input bit fill);
        logic [31:0] data [$];
        logic [3:0]  strb [$];
        logic [31:0] r;
        logic [15:0] addr;
        axi_resp_e   resp;
        int          nbeats;
        nbeats = int'(len) + 1;
        addr   = start;
        resp   = AXI_RESP_OKAY;
        // Precompute beats so the model leads the DUT
        for (int k = 0; k < nbeats; k++) begin
            r = $random(seed);
            data.push_back(fill ? {addr, ~addr} : r);
            r = $random(seed);
            strb.push_back(rand_strb ? r[3:0] : 4'hf);
            if (addr[15:8] != 8'h00) begin
                resp = AXI_RESP_SLVERR;
            end else begin
                model_write(addr[7:2], data[k], strb[k]);
            end
            addr = next_beat_addr(addr, start, burst, len);
        end
        exp_q.push_back({resp, id});
        r         = $random(seed);
        i_awvalid = 1'b1;
        i_awaddr  = start;
        i_awburst = burst;
        i_awsize  = 3'd2;
        i_awlen   = len;
        i_awuser  = r[7:0];
        i_awid    = id;
        // Ready is registered, so the falling edge value holds through the rising edge
        while (!o_awready) begin
            @(negedge clk);
        end
        @(negedge clk);
        i_awvalid = 1'b0;
        for (int k = 0; k < nbeats; k++) begin
            i_wvalid = 1'b1;
            i_wdata  = data[k];
            i_wstrb  = strb[k];
            i_wlast  = (k == nbeats - 1);
            while (!o_wready) begin
                @(negedge clk);
            end
            @(negedge clk);
        end
        i_wvalid = 1'b0;
        i_wlast  = 1'b0;
    endtask

    task automatic collect_responses(input int n, input bit rand_ready);
        logic [31:0]       r;
        logic [AXI_IW+1:0] want;
        int                got;
        got = 0;
        while (got < n) begin
            r        = $random(seed);
            i_bready = rand_ready ? (r[1:0] != 2'b00) : 1'b1;
            if (o_bvalid && i_bready) begin
                assert (exp_q.size() > 0)
                    else report_error("write response arrived with no burst outstanding");
                if (exp_q.size() > 0) begin
                    want = exp_q.pop_front();
                    assert (o_bid == want[AXI_IW-1:0])
                        else report_mismatch("o_bid", 32'(o_bid), 32'(want[AXI_IW-1:0]));
                    assert (o_bresp == want[AXI_IW+1:AXI_IW])
                        else report_mismatch("o_bresp", 32'(o_bresp),
                                             32'(want[AXI_IW+1:AXI_IW]));
                end
                got++;
            end
            @(negedge clk);
        end
        i_bready = 1'b0;
    endtask

    task automatic check_read_data(input logic [5:0] idx);
        assert (o_rd_data == model[idx])
            else report_mismatch($sformatf("o_rd_data word %0d", idx), o_rd_data, model[idx]);
    endtask

    task automatic read_check(input logic [5:0] idx);
        i_rd_en   = 1'b1;
        i_rd_addr = idx;
        @(negedge clk);
        i_rd_en = 1'b0;
        check_read_data(idx);
    endtask

    // Reads of words 0 to 31 raise hld while bursts target the upper half
    task automatic random_reads();
        logic [31:0] r;
        logic [5:0]  idx;
        bit          pend;
        pend = 1'b0;
        idx  = '0;
        while (!resp_done) begin
            if (pend) begin
                check_read_data(idx);
            end
            r         = $random(seed);
            pend      = r[0];
            idx       = {1'b0, r[5:1]};
            i_rd_en   = pend;
            i_rd_addr = idx;
            @(negedge clk);
        end
        if (pend) begin
            check_read_data(idx);
        end
        i_rd_en = 1'b0;
    endtask

    task automatic run_backpressure();
        logic [15:0] starts [6] = '{16'h00a0, 16'h00b4, 16'h00c0,
                                    16'h00d0, 16'h00e2, 16'h00f8};
        axi_burst_e  bursts [6] = '{AXI_BURST_INCR, AXI_BURST_WRAP, AXI_BURST_FIXED,
                                    AXI_BURST_INCR, AXI_BURST_INCR, AXI_BURST_INCR};
        logic [7:0]  lens [6]   = '{8'd3, 8'd3, 8'd2, 8'd0, 8'd5, 8'd3};
        resp_done = 1'b0;
        fork
            begin
                for (int b = 0; b < 6; b++) begin
                    send_burst(starts[b], bursts[b], lens[b], 4'(b + 1), 1'b1, 1'b0);
                end
            end
            begin
                collect_responses(6, 1'b1);
                resp_done = 1'b1;
            end
            random_reads();
        join
        for (int w = 0; w < MEM_WORDS; w++) begin
            read_check(6'(w));
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        seed      = 32'hc7146304;
        err_cnt   = 0;
        err_mark  = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        resp_done = 1'b0;
        rst_n     = 1'b0;
        i_awvalid = 1'b0;
        i_awaddr  = '0;
        i_awburst = 2'b01;
        i_awsize  = 3'd2;
        i_awlen   = '0;
        i_awuser  = '0;
        i_awid    = '0;
        i_wvalid  = 1'b0;
        i_wdata   = '0;
        i_wstrb   = '0;
        i_wlast   = 1'b0;
        i_bready  = 1'b0;
        i_rd_en   = 1'b0;
        i_rd_addr = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Known contents everywhere before partial strobes
        send_burst(16'h0000, AXI_BURST_INCR, 8'd63, 4'h0, 1'b0, 1'b1);
        collect_responses(1, 1'b0);
        for (int w = 0; w < MEM_WORDS; w++) begin
            read_check(6'(w));
        end
        end_test("fill");

        send_burst(16'h0010, AXI_BURST_INCR, 8'd0, 4'h3, 1'b0, 1'b0);
        collect_responses(1, 1'b0);
        read_check(6'd4);
        end_test("single_write");

        // Unaligned start, first beat lands on word 16
        send_burst(16'h0042, AXI_BURST_INCR, 8'd7, 4'h5, 1'b1, 1'b0);
        collect_responses(1, 1'b0);
        for (int w = 15; w < 25; w++) begin
            read_check(6'(w));
        end
        end_test("incr_strobes");

        // Words 26 27 24 25
        send_burst(16'h0068, AXI_BURST_WRAP, 8'd3, 4'h7, 1'b1, 1'b0);
        collect_responses(1, 1'b0);
        for (int w = 23; w < 29; w++) begin
            read_check(6'(w));
        end
        end_test("wrap_burst");

        send_burst(16'h0030, AXI_BURST_FIXED, 8'd3, 4'h9, 1'b1, 1'b0);
        collect_responses(1, 1'b0);
        for (int w = 11; w < 14; w++) begin
            read_check(6'(w));
        end
        end_test("fixed_burst");

        // Words 61 to 64, the last beat is dropped
        send_burst(16'h00f4, AXI_BURST_INCR, 8'd3, 4'ha, 1'b0, 1'b0);
        collect_responses(1, 1'b0);
        for (int w = 59; w < 64; w++) begin
            read_check(6'(w));
        end
        // Dropped beat at 0x100 shares its low index bits with word 0
        read_check(6'd0);
        end_test("out_of_range");

        run_backpressure();
        end_test("backpressure_order");

        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- axi_wr_mem_top.f
rtl/axi_pkg.sv
rtl/axi_if.sv
rtl/comp_wr_if.sv
rtl/skid_buffer.sv
rtl/axi_addr_step.sv
rtl/axi_sub_wr.sv
rtl/wr_mem.sv
rtl/axi_wr_mem_top.sv
bench/tb_axi_wr_mem.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_axi_wr_mem -f axi_wr_mem_top.f -o sim_tb

out=$(./obj_dir/sim_tb || true)
echo "$out"
echo "$out" | grep -q "TB PASSED"
